// ==== include/lc4_params.svh ====
`ifndef LC4_PARAMS_SVH
`define LC4_PARAMS_SVH

// data and address width
`define LC4_XLEN 16

// register file geometry
`define LC4_NREGS 8
`define LC4_RSEL_W 3

// condition code width with N in bit 2 and P in bit 0
`define LC4_NZP_W 3

// first fetch address out of reset
`define LC4_RESET_PC 16'h8200

// instruction field widths
`define LC4_OPC_W 4
`define LC4_IMM5_W 5
`define LC4_IMM6_W 6
`define LC4_IMM9_W 9

`endif

// ==== design/lc4_pkg.sv ====
`default_nettype none
`include "lc4_params.svh"

package lc4_pkg;

    typedef logic [`LC4_XLEN-1:0] word_t;
    typedef logic [`LC4_RSEL_W-1:0] rsel_t;
    typedef logic [`LC4_NZP_W-1:0] nzp_t;

    typedef enum logic [`LC4_OPC_W-1:0] {
        OP_BR    = 4'b0000,
        OP_ARITH = 4'b0001,
        OP_LOGIC = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_CONST = 4'b1001
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_IMM,
        ALU_ADDR,
        ALU_BR_TGT
    } alu_op_e;

    typedef struct packed {
        rsel_t   rs_sel;
        rsel_t   rt_sel;
        rsel_t   rd_sel;
        logic    rs_re;
        logic    rt_re;
        logic    rd_we;
        logic    nzp_we;
        logic    is_load;
        logic    is_store;
        logic    is_branch;
        alu_op_e alu_op;
        word_t   imm;
        nzp_t    br_cond;
    } ctrl_t;

    // why a slot reaching W carries no instruction
    typedef enum logic [1:0] {
        STALL_NONE         = 2'd0,
        STALL_BRANCH_FLUSH = 2'd2,
        STALL_LOAD         = 2'd3
    } stall_e;

    typedef enum logic [1:0] {
        FWD_REGFILE,
        FWD_FROM_M,
        FWD_FROM_W
    } fwd_sel_e;

    typedef struct packed {
        word_t addr;
        logic  we;
        word_t wdata;
    } dmem_req_t;

    typedef struct packed {
        logic   valid;
        stall_e stall;
        word_t  pc;
        word_t  insn;
        logic   rd_we;
        rsel_t  rd;
        word_t  wdata;
        nzp_t   nzp;
    } retire_t;

    // sign of a value as the one-hot N/Z/P code
    function automatic nzp_t nzp_of(input word_t value);
        if (value == '0) begin
            return 3'b010;
        end
        return value[`LC4_XLEN-1] ? 3'b100 : 3'b001;
    endfunction

endpackage

`default_nettype wire

// ==== design/lc4_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lc4_params.svh"

module lc4_decoder
    import lc4_pkg::*;
(
    input  wire word_t i_insn,
    output ctrl_t      o_ctrl
);
    opcode_e opc;

    // low bits of field hold the immediate and the rest is shifted out
    function automatic word_t sext(input word_t field, input int unsigned width);
        word_t shifted;
        shifted = field << (`LC4_XLEN - width);
        return word_t'($signed(shifted) >>> (`LC4_XLEN - width));
    endfunction

    assign opc = opcode_e'(i_insn[15:12]);

    always_comb begin
        o_ctrl = '0;
        case (opc)
            OP_BR: begin
                // all condition bits clear is the NOP
                if (i_insn[11:9] != '0) begin
                    o_ctrl.is_branch = 1'b1;
                    o_ctrl.br_cond   = i_insn[11:9];
                    o_ctrl.alu_op    = ALU_BR_TGT;
                    o_ctrl.imm       = sext(i_insn, `LC4_IMM9_W);
                end
            end
            OP_ARITH, OP_LOGIC: begin
                o_ctrl.rd_sel = i_insn[11:9];
                o_ctrl.rs_sel = i_insn[8:6];
                o_ctrl.rt_sel = i_insn[2:0];
                o_ctrl.rs_re  = 1'b1;
                o_ctrl.rt_re  = !i_insn[5];
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
                o_ctrl.imm    = sext(i_insn, `LC4_IMM5_W);
                if (i_insn[5]) begin
                    o_ctrl.alu_op = (opc == OP_ARITH) ? ALU_ADD : ALU_AND;
                end else begin
                    case ({opc == OP_LOGIC, i_insn[4:3]})
                        3'b000:  o_ctrl.alu_op = ALU_ADD;
                        3'b010:  o_ctrl.alu_op = ALU_SUB;
                        3'b100:  o_ctrl.alu_op = ALU_AND;
                        3'b110:  o_ctrl.alu_op = ALU_OR;
                        3'b111:  o_ctrl.alu_op = ALU_XOR;
                        // MUL, DIV and NOT fall back to a NOP
                        default: o_ctrl = '0;
                    endcase
                end
            end
            OP_LDR: begin
                o_ctrl.rd_sel  = i_insn[11:9];
                o_ctrl.rs_sel  = i_insn[8:6];
                o_ctrl.rs_re   = 1'b1;
                o_ctrl.rd_we   = 1'b1;
                o_ctrl.nzp_we  = 1'b1;
                o_ctrl.is_load = 1'b1;
                o_ctrl.alu_op  = ALU_ADDR;
                o_ctrl.imm     = sext(i_insn, `LC4_IMM6_W);
            end
            OP_STR: begin
                // store data comes in on the rt port
                o_ctrl.rt_sel   = i_insn[11:9];
                o_ctrl.rs_sel   = i_insn[8:6];
                o_ctrl.rs_re    = 1'b1;
                o_ctrl.rt_re    = 1'b1;
                o_ctrl.is_store = 1'b1;
                o_ctrl.alu_op   = ALU_ADDR;
                o_ctrl.imm      = sext(i_insn, `LC4_IMM6_W);
            end
            OP_CONST: begin
                o_ctrl.rd_sel = i_insn[11:9];
                o_ctrl.rd_we  = 1'b1;
                o_ctrl.nzp_we = 1'b1;
                o_ctrl.alu_op = ALU_PASS_IMM;
                o_ctrl.imm    = sext(i_insn, `LC4_IMM9_W);
            end
            default: o_ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/lc4_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lc4_params.svh"

module lc4_regfile
    import lc4_pkg::*;
(
    input  wire logic  gwe,
    input  wire logic  i_reset,
    input  wire rsel_t i_rs_sel,
    input  wire rsel_t i_rt_sel,
    output word_t      o_rs_data,
    output word_t      o_rt_data,
    input  wire rsel_t i_rd_sel,
    input  wire logic  i_rd_we,
    input  wire word_t i_rd_data
);
    word_t regs [`LC4_NREGS];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < `LC4_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // write-through so D sees the value W retires in the same cycle
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule

`default_nettype wire

// ==== design/lc4_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_alu
    import lc4_pkg::*;
(
    input  wire alu_op_e i_op,
    input  wire word_t   i_a,
    input  wire word_t   i_b,
    input  wire word_t   i_imm,
    input  wire word_t   i_pc,
    output word_t        o_result,
    output nzp_t         o_nzp
);

    always_comb begin
        case (i_op)
            ALU_ADD:      o_result = i_a + i_b;
            ALU_SUB:      o_result = i_a - i_b;
            ALU_AND:      o_result = i_a & i_b;
            ALU_OR:       o_result = i_a | i_b;
            ALU_XOR:      o_result = i_a ^ i_b;
            ALU_PASS_IMM: o_result = i_imm;
            // base plus offset for loads and stores
            ALU_ADDR:     o_result = i_a + i_imm;
            // branch target is relative to the next PC
            ALU_BR_TGT:   o_result = i_pc + 1'b1 + i_imm;
            default:      o_result = '0;
        endcase
    end

    assign o_nzp = nzp_of(o_result);

endmodule

`default_nettype wire

// ==== design/lc4_hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_hazard_unit
    import lc4_pkg::*;
(
    input  wire ctrl_t i_d_ctrl,
    input  wire ctrl_t i_x_ctrl,
    input  wire ctrl_t i_m_ctrl,
    input  wire ctrl_t i_w_ctrl,
    input  wire logic  i_branch_taken,
    output fwd_sel_e   o_fwd_rs,
    output fwd_sel_e   o_fwd_rt,
    output logic       o_fwd_store,
    output logic       o_stall,
    output logic       o_flush
);
    logic load_use;
    logic load_branch;

    function automatic fwd_sel_e src_of(input rsel_t sel, input logic re,
                                        input ctrl_t m, input ctrl_t w);
        fwd_sel_e src;
        src = FWD_REGFILE;
        if (re && w.rd_we && w.rd_sel == sel) begin
            src = FWD_FROM_W;
        end
        // the younger producer in M wins but a load in M has no data yet
        if (re && m.rd_we && !m.is_load && m.rd_sel == sel) begin
            src = FWD_FROM_M;
        end
        return src;
    endfunction

    assign o_fwd_rs = src_of(i_x_ctrl.rs_sel, i_x_ctrl.rs_re, i_m_ctrl, i_w_ctrl);
    assign o_fwd_rt = src_of(i_x_ctrl.rt_sel, i_x_ctrl.rt_re, i_m_ctrl, i_w_ctrl);

    // store data still stale in M is patched from W
    assign o_fwd_store = i_m_ctrl.is_store && i_w_ctrl.rd_we
                         && i_w_ctrl.rd_sel == i_m_ctrl.rt_sel;

    // store data is left out here since W-to-M bypass covers it
    assign load_use = i_x_ctrl.is_load
                      && ((i_d_ctrl.rs_re && i_d_ctrl.rs_sel == i_x_ctrl.rd_sel)
                          || (i_d_ctrl.rt_re && !i_d_ctrl.is_store
                              && i_d_ctrl.rt_sel == i_x_ctrl.rd_sel));

    // loads set NZP at the end of M, too late for a branch right behind
    assign load_branch = i_x_ctrl.is_load && i_d_ctrl.is_branch;

    assign o_flush = i_branch_taken;
    assign o_stall = (load_use || load_branch) && !i_branch_taken;

endmodule

`default_nettype wire

// ==== design/lc4_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lc4_params.svh"

module lc4_pipeline
    import lc4_pkg::*;
(
    input  wire logic  gwe,
    input  wire logic  i_reset,
    output word_t      o_imem_addr,
    input  wire word_t i_imem_insn,
    output dmem_req_t  o_dmem,
    input  wire word_t i_dmem_rdata,
    output retire_t    o_retire
);
    word_t    pc_q;
    nzp_t     nzp_q;

    logic     d_valid;
    stall_e   d_stall;
    word_t    d_pc, d_insn, d_rs_data, d_rt_data;
    ctrl_t    d_dec, d_ctrl;

    logic     x_valid;
    stall_e   x_stall;
    ctrl_t    x_ctrl;
    word_t    x_pc, x_insn, x_rs_data, x_rt_data;
    word_t    x_a, x_rt_fwd, x_result;
    nzp_t     x_nzp;

    logic     m_valid;
    stall_e   m_stall;
    ctrl_t    m_ctrl;
    word_t    m_pc, m_insn, m_alu, m_rt_data, m_store_data;

    logic     w_valid;
    stall_e   w_stall;
    ctrl_t    w_ctrl;
    word_t    w_pc, w_insn, w_alu, w_ld_data, w_wdata;

    logic     branch_taken;
    logic     stall;
    logic     flush;
    logic     fwd_store;
    fwd_sel_e fwd_rs;
    fwd_sel_e fwd_rt;

    function automatic word_t bypass(input fwd_sel_e sel, input word_t rf_val,
                                     input word_t m_val, input word_t w_val);
        case (sel)
            FWD_FROM_M: return m_val;
            FWD_FROM_W: return w_val;
            default:    return rf_val;
        endcase
    endfunction

    lc4_decoder lc4_decoder_inst (
        .i_insn (d_insn),
        .o_ctrl (d_dec)
    );

    // a bubble in D must not look like an instruction to the hazard unit
    assign d_ctrl = d_valid ? d_dec : '0;

    lc4_regfile lc4_regfile_inst (
        .gwe       (gwe),
        .i_reset   (i_reset),
        .i_rs_sel  (d_ctrl.rs_sel),
        .i_rt_sel  (d_ctrl.rt_sel),
        .o_rs_data (d_rs_data),
        .o_rt_data (d_rt_data),
        .i_rd_sel  (w_ctrl.rd_sel),
        .i_rd_we   (w_ctrl.rd_we),
        .i_rd_data (w_wdata)
    );

    assign x_a      = bypass(fwd_rs, x_rs_data, m_alu, w_wdata);
    assign x_rt_fwd = bypass(fwd_rt, x_rt_data, m_alu, w_wdata);

    lc4_alu lc4_alu_inst (
        .i_op     (x_ctrl.alu_op),
        .i_a      (x_a),
        .i_b      (x_ctrl.rt_re ? x_rt_fwd : x_ctrl.imm),
        .i_imm    (x_ctrl.imm),
        .i_pc     (x_pc),
        .o_result (x_result),
        .o_nzp    (x_nzp)
    );

    assign branch_taken = x_ctrl.is_branch && ((x_ctrl.br_cond & nzp_q) != '0);

    lc4_hazard_unit lc4_hazard_unit_inst (
        .i_d_ctrl       (d_ctrl),
        .i_x_ctrl       (x_ctrl),
        .i_m_ctrl       (m_ctrl),
        .i_w_ctrl       (w_ctrl),
        .i_branch_taken (branch_taken),
        .o_fwd_rs       (fwd_rs),
        .o_fwd_rt       (fwd_rt),
        .o_fwd_store    (fwd_store),
        .o_stall        (stall),
        .o_flush        (flush)
    );

    // a flush or stall turns the slot into a bubble
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc_q    <= `LC4_RESET_PC;
            d_valid <= 1'b0;
            d_stall <= STALL_NONE;
            x_valid <= 1'b0;
            x_stall <= STALL_NONE;
            x_ctrl  <= '0;
            m_valid <= 1'b0;
            m_stall <= STALL_NONE;
            m_ctrl  <= '0;
            w_valid <= 1'b0;
            w_stall <= STALL_NONE;
            w_ctrl  <= '0;
        end else begin
            m_valid <= x_valid;
            m_stall <= x_stall;
            m_ctrl  <= x_ctrl;
            w_valid <= m_valid;
            w_stall <= m_stall;
            w_ctrl  <= m_ctrl;
            if (flush) begin
                pc_q    <= x_result;
                d_valid <= 1'b0;
                d_stall <= STALL_BRANCH_FLUSH;
                x_valid <= 1'b0;
                x_stall <= STALL_BRANCH_FLUSH;
                x_ctrl  <= '0;
            end else if (stall) begin
                // F and D hold while X takes the bubble
                x_valid <= 1'b0;
                x_stall <= STALL_LOAD;
                x_ctrl  <= '0;
            end else begin
                pc_q    <= pc_q + 1'b1;
                d_valid <= 1'b1;
                d_stall <= STALL_NONE;
                x_valid <= d_valid;
                x_stall <= d_stall;
                x_ctrl  <= d_ctrl;
            end
        end
    end

    always_ff @(posedge gwe) begin
        if (!stall) begin
            d_pc   <= pc_q;
            d_insn <= i_imem_insn;
        end
        x_pc      <= d_pc;
        x_insn    <= d_insn;
        x_rs_data <= d_rs_data;
        x_rt_data <= d_rt_data;
        m_pc      <= x_pc;
        m_insn    <= x_insn;
        m_alu     <= x_result;
        m_rt_data <= x_rt_fwd;
        w_pc      <= m_pc;
        w_insn    <= m_insn;
        w_alu     <= m_alu;
        w_ld_data <= i_dmem_rdata;
    end

    // ALU results land at the end of X and loads at the end of M
    // so the younger one in X wins when both arrive together
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            nzp_q <= '0;
        end else if (x_ctrl.nzp_we && !x_ctrl.is_load) begin
            nzp_q <= x_nzp;
        end else if (m_ctrl.is_load) begin
            nzp_q <= nzp_of(i_dmem_rdata);
        end
    end

    assign o_imem_addr  = pc_q;
    assign m_store_data = fwd_store ? w_wdata : m_rt_data;

    always_comb begin
        o_dmem.addr  = (m_ctrl.is_load || m_ctrl.is_store) ? m_alu : '0;
        o_dmem.we    = m_ctrl.is_store;
        o_dmem.wdata = m_ctrl.is_store ? m_store_data : '0;
    end

    assign w_wdata = w_ctrl.is_load ? w_ld_data : w_alu;

    always_comb begin
        o_retire.valid = w_valid;
        o_retire.stall = w_stall;
        o_retire.pc    = w_pc;
        o_retire.insn  = w_insn;
        o_retire.rd_we = w_ctrl.rd_we;
        o_retire.rd    = w_ctrl.rd_sel;
        o_retire.wdata = w_wdata;
        o_retire.nzp   = w_ctrl.nzp_we ? nzp_of(w_wdata) : '0;
    end

endmodule

`default_nettype wire

// ==== verif/lc4_pipeline_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc4_pipeline_sva
    import lc4_pkg::*;
(
    input wire logic      gwe,
    input wire logic      i_reset,
    input wire dmem_req_t i_dmem,
    input wire retire_t   i_retire
);

    // memory must stay quiet once reset has cleared M
    a_no_store_after_reset: assert property (@(posedge gwe) i_reset |=> !i_dmem.we)
        else $error("store strobe high in the cycle after reset");

    // a retiring instruction is never tagged as a bubble
    a_retire_no_reason: assert property (@(posedge gwe) disable iff (i_reset)
        i_retire.valid |-> i_retire.stall == STALL_NONE)
        else $error("valid retire carries a bubble reason");

    // flush bubbles come in pairs since D and X are both squashed
    a_flush_pairs: assert property (@(posedge gwe) disable iff (i_reset)
        (i_retire.stall == STALL_BRANCH_FLUSH && $past(i_retire.stall) != STALL_BRANCH_FLUSH)
        |=> i_retire.stall == STALL_BRANCH_FLUSH)
        else $error("branch flush bubble not followed by a second one");

endmodule

bind lc4_pipeline lc4_pipeline_sva lc4_pipeline_sva_inst (
    .gwe      (gwe),
    .i_reset  (i_reset),
    .i_dmem   (o_dmem),
    .i_retire (o_retire)
);

`default_nettype wire

// ==== verif/tb_lc4_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lc4_params.svh"

module tb_lc4_pipeline
    import lc4_pkg::*;
();
    localparam int PROG_LEN   = 64;
    // NOP padding so a forward branch near the end still lands in memory
    localparam int MEM_WORDS  = PROG_LEN + 8;
    localparam int MAX_CYCLES = 4 * PROG_LEN + 20;

    logic      gwe;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_insn;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;
    retire_t   retire;

    word_t     imem [MEM_WORDS];
    word_t     dmem [256];
    word_t     model_mem [256];
    word_t     model_regs [`LC4_NREGS];
    retire_t   exp_q [$];
    dmem_req_t store_q [$];

    integer    seed;
    int        cycle_cnt;
    int        retire_cnt;
    int        store_cnt;
    int        exp_load_stalls;
    int        seen_load_stalls;
    int        exp_flushes;
    int        seen_flushes;

    lc4_pipeline lc4_pipeline_inst (
        .gwe          (gwe),
        .i_reset      (reset),
        .o_imem_addr  (imem_addr),
        .i_imem_insn  (imem_insn),
        .o_dmem       (dmem_req),
        .i_dmem_rdata (dmem_rdata),
        .o_retire     (retire)
    );

    always #50 gwe = ~gwe;

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // N/Z/P code of a value as the ISA defines it
    function automatic logic [2:0] sign_code(input word_t v);
        if (v[15]) begin
            return 3'b100;
        end else if (v == 16'h0000) begin
            return 3'b010;
        end
        return 3'b001;
    endfunction

    function automatic word_t fill_word(input int unsigned a);
        return word_t'((a * 32'd40503) ^ 32'h0000c3a5);
    endfunction

    function automatic word_t fetch_word(input word_t addr);
        word_t offset;
        offset = addr - `LC4_RESET_PC;
        if (addr >= `LC4_RESET_PC && offset < MEM_WORDS) begin
            return imem[offset];
        end
        return 16'h0000;
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_val(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        assert (act == exp) else begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // random program with store/load and load/store pairs mixed in
    task automatic gen_program();
        word_t       follow;
        logic        have_follow;
        logic [2:0]  r_a, r_b, r_c;
        logic [1:0]  sub;
        logic [5:0]  off;
        int unsigned k;
        have_follow = 1'b0;
        follow = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            r_a = 3'(pick(8));
            r_b = 3'(pick(8));
            r_c = 3'(pick(8));
            off = 6'(pick(64));
            if (have_follow) begin
                imem[i] = follow;
                have_follow = 1'b0;
            end else begin
                case (pick(10))
                    0, 1: begin
                        k = pick(5);
                        sub = (k == 4) ? 2'b11 : (k[0] ? 2'b10 : 2'b00);
                        imem[i] = {(k < 2) ? OP_ARITH : OP_LOGIC, r_a, r_b, 1'b0, sub, r_c};
                    end
                    2: imem[i] = {OP_ARITH, r_a, r_b, 1'b1, 5'(pick(32))};
                    3: imem[i] = {OP_LOGIC, r_a, r_b, 1'b1, 5'(pick(32))};
                    4, 5: imem[i] = {OP_CONST, r_a, 9'(pick(512))};
                    6: begin
                        imem[i] = {OP_LDR, r_a, r_b, off};
                        // loaded value used as store data right away
                        follow = {OP_STR, r_a, r_c, 6'(pick(64))};
                        have_follow = (pick(2) == 0);
                    end
                    7: begin
                        imem[i] = {OP_STR, r_a, r_b, off};
                        // read back the same word
                        follow = {OP_LDR, r_c, r_b, off};
                        have_follow = (pick(2) == 0);
                    end
                    default: imem[i] = {OP_BR, 3'(pick(8)), 6'b000000, 3'(pick(8))};
                endcase
            end
        end
        for (int i = PROG_LEN; i < MEM_WORDS; i++) begin
            imem[i] = 16'h0000;
        end
    endtask

    // sequential ISA model that builds the expected retire stream with bubbles
    task automatic build_model();
        word_t   pc, insn, a, b, result, addr;
        logic    [2:0] nzp;
        logic    reads_rs, reads_rt, writes, is_load, is_br, prev_load;
        rsel_t   prev_rd;
        retire_t rec, bubble;
        dmem_req_t st;
        pc = `LC4_RESET_PC;
        nzp = 3'b000;
        prev_load = 1'b0;
        prev_rd = '0;
        bubble = '0;
        for (int r = 0; r < `LC4_NREGS; r++) begin
            model_regs[r] = '0;
        end
        // branches only go forward, so this walk ends
        while (pc - `LC4_RESET_PC < MEM_WORDS) begin
            insn = imem[pc - `LC4_RESET_PC];
            a = model_regs[insn[8:6]];
            b = model_regs[insn[2:0]];
            reads_rs = 1'b0;
            reads_rt = 1'b0;
            writes = 1'b0;
            is_load = 1'b0;
            is_br = 1'b0;
            result = '0;
            case (insn[15:12])
                OP_ARITH, OP_LOGIC: begin
                    reads_rs = 1'b1;
                    writes = 1'b1;
                    if (insn[5]) begin
                        b = {{11{insn[4]}}, insn[4:0]};
                    end else begin
                        reads_rt = 1'b1;
                    end
                    if (insn[15:12] == OP_ARITH) begin
                        result = (!insn[5] && insn[4]) ? a - b : a + b;
                    end else if (insn[5] || insn[4:3] == 2'b00) begin
                        result = a & b;
                    end else if (insn[4:3] == 2'b10) begin
                        result = a | b;
                    end else begin
                        result = a ^ b;
                    end
                end
                OP_LDR: begin
                    reads_rs = 1'b1;
                    writes = 1'b1;
                    is_load = 1'b1;
                    addr = a + {{10{insn[5]}}, insn[5:0]};
                    result = model_mem[addr[7:0]];
                end
                OP_STR: begin
                    reads_rs = 1'b1;
                    st.addr = a + {{10{insn[5]}}, insn[5:0]};
                    st.we = 1'b1;
                    st.wdata = model_regs[insn[11:9]];
                    store_q.push_back(st);
                    model_mem[st.addr[7:0]] = st.wdata;
                end
                OP_CONST: begin
                    writes = 1'b1;
                    result = {{7{insn[8]}}, insn[8:0]};
                end
                OP_BR: is_br = (insn[11:9] != 3'b000);
                default: ;
            endcase
            if (prev_load && (is_br || (reads_rs && insn[8:6] == prev_rd)
                              || (reads_rt && insn[2:0] == prev_rd))) begin
                bubble.stall = STALL_LOAD;
                exp_q.push_back(bubble);
                exp_load_stalls++;
            end
            rec = '0;
            rec.valid = 1'b1;
            rec.stall = STALL_NONE;
            rec.pc = pc;
            rec.insn = insn;
            rec.rd_we = writes;
            if (writes) begin
                rec.rd = insn[11:9];
                rec.wdata = result;
                rec.nzp = sign_code(result);
                model_regs[insn[11:9]] = result;
                nzp = sign_code(result);
            end
            exp_q.push_back(rec);
            prev_load = is_load;
            prev_rd = insn[11:9];
            if (is_br && (insn[11:9] & nzp) != 3'b000) begin
                bubble.stall = STALL_BRANCH_FLUSH;
                exp_q.push_back(bubble);
                exp_q.push_back(bubble);
                exp_flushes += 2;
                pc = pc + 16'd1 + {{7{insn[8]}}, insn[8:0]};
            end else begin
                pc = pc + 16'd1;
            end
        end
    endtask

    // check a store and answer both memory ports for the next edge
    task automatic service_memories();
        dmem_req_t st;
        if (dmem_req.we) begin
            assert (store_q.size() != 0) else begin
                $display("ERROR: store to %h that the program never makes", dmem_req.addr);
                abort_run();
            end
            st = store_q.pop_front();
            check_val($sformatf("store %0d address", store_cnt), st.addr, dmem_req.addr);
            check_val($sformatf("store %0d data", store_cnt), st.wdata, dmem_req.wdata);
            dmem[dmem_req.addr[7:0]] = dmem_req.wdata;
            store_cnt++;
        end
        dmem_rdata = dmem[dmem_req.addr[7:0]];
        imem_insn = fetch_word(imem_addr);
    endtask

    task automatic observe_retire();
        retire_t exp;
        string   tag;
        // reset bubbles drain out before the first program slot
        if (retire_cnt == 0 && !retire.valid && retire.stall == STALL_NONE) begin
            return;
        end
        exp = exp_q.pop_front();
        tag = $sformatf("retire %0d", retire_cnt);
        check_val({tag, " valid"}, exp.valid, retire.valid);
        check_val({tag, " stall"}, exp.stall, retire.stall);
        if (retire.stall == STALL_LOAD) begin
            seen_load_stalls++;
        end
        if (retire.stall == STALL_BRANCH_FLUSH) begin
            seen_flushes++;
        end
        if (exp.valid) begin
            check_val({tag, " pc"}, exp.pc, retire.pc);
            check_val({tag, " insn"}, exp.insn, retire.insn);
            check_val({tag, " rd_we"}, exp.rd_we, retire.rd_we);
            if (exp.rd_we) begin
                check_val({tag, " rd"}, exp.rd, retire.rd);
                check_val({tag, " wdata"}, exp.wdata, retire.wdata);
                check_val({tag, " nzp"}, exp.nzp, retire.nzp);
            end
        end
        retire_cnt++;
    endtask

    initial begin
        gwe = 1'b0;
        reset = 1'b1;
        imem_insn = '0;
        dmem_rdata = '0;
        seed = 32'h1c27;
        cycle_cnt = 0;
        retire_cnt = 0;
        store_cnt = 0;
        exp_load_stalls = 0;
        seen_load_stalls = 0;
        exp_flushes = 0;
        seen_flushes = 0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        gen_program();
        build_model();

        repeat (2) begin
            @(negedge gwe);
            check_val("reset retire valid", '0, retire.valid);
            check_val("reset dmem we", '0, dmem_req.we);
            check_val("reset imem addr", `LC4_RESET_PC, imem_addr);
            service_memories();
        end
        reset = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge gwe);
            cycle_cnt++;
            if (cycle_cnt > MAX_CYCLES) begin
                $display("ERROR: timeout after %0d cycles, %0d retire records still expected",
                         cycle_cnt, exp_q.size());
                abort_run();
            end
            service_memories();
            observe_retire();
        end

        check_count("load_stall bubbles", exp_load_stalls, seen_load_stalls);
        check_count("branch_flush bubbles", exp_flushes, seen_flushes);
        check_count("stores not seen", 0, store_q.size());
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
design/lc4_pkg.sv
design/lc4_decoder.sv
design/lc4_regfile.sv
design/lc4_alu.sv
design/lc4_hazard_unit.sv
design/lc4_pipeline.sv
verif/lc4_pipeline_sva.sv
verif/tb_lc4_pipeline.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the LC4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lc4_pipeline \
    -Mdir "$OBJ_DIR" \
    -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/Vtb_lc4_pipeline" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation returned status $run_status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
